// File: source/branchUnit_macros.svh
`ifndef BRANCHUNIT_MACROS_SVH
`define BRANCHUNIT_MACROS_SVH

// unconditional branch opcodes
// register and immediate forms
`define BU_OPC_BRU  6'o46
`define BU_OPC_BRUI 6'o56

// conditional branch opcodes
`define BU_OPC_BCC  6'o47
`define BU_OPC_BCCI 6'o57

// word address width of the fetch side
`define BU_PC_W 30

`endif

// File: source/branchPkg.sv
`include "branchUnit_macros.svh"

package branchPkg;

  // register form of the instruction word
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] alt;
  } regForm_t;

  // immediate form with a 16 bit literal
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] imm;
  } immForm_t;

  // one 32 bit word seen through either encoding
  typedef union packed {
    regForm_t regForm;
    immForm_t immForm;
  } instWord_u;

  // branch condition as carried in rd[2:0]
  typedef enum logic [2:0] {
    condEq = 3'd0,
    condNe = 3'd1,
    condLt = 3'd2,
    condLe = 3'd3,
    condGt = 3'd4,
    condGe = 3'd5
  } branchCond_e;

  // decoded branch control for the resolver
  typedef struct packed {
    logic        isBranch;
    logic        isUncond;
    branchCond_e cond;
    logic        delaySlot;
  } condCtrl_t;

  // zero and sign of the captured compare operand
  typedef struct packed {
    logic isZero;
    logic isNeg;
  } opFlags_t;

  // forwarding source picked by the hazard logic
  typedef enum logic [1:0] {
    fwdReg = 2'd0,
    fwdAlu = 2'd1,
    fwdIo  = 2'd2
  } fwdSel_e;

  // fetch side word address
  typedef logic [`BU_PC_W-1:0] pcWord_t;

endpackage

// File: source/branchDecode.sv
`timescale 1ns/1ps
`include "branchUnit_macros.svh"

module branchDecode
  import branchPkg::*;
(
  input  logic      gclk,
  input  logic      arstN,
  input  logic      decEn,
  input  instWord_u inst,
  input  logic      squash,
  input  logic      flush,
  output condCtrl_t ctrl
);

  // idle value of the control register
  // resolver sees this as never taken
  localparam condCtrl_t nonBranch = '{
    isBranch:  1'b0,
    isUncond:  1'b0,
    cond:      condEq,
    delaySlot: 1'b0
  };

  logic [5:0] opcode;
  logic       isBru;
  logic       isBcc;
  condCtrl_t  decoded;

  // opcode and rd read through the register view
  assign opcode = inst.regForm.opcode;

  // both encodings of each branch class
  assign isBru = (opcode == `BU_OPC_BRU) || (opcode == `BU_OPC_BRUI);
  assign isBcc = (opcode == `BU_OPC_BCC) || (opcode == `BU_OPC_BCCI);

  always_comb begin
    decoded = nonBranch;
    if (isBru) begin
      // unconditional with the delay bit in ra[4]
      decoded.isBranch  = 1'b1;
      decoded.isUncond  = 1'b1;
      decoded.delaySlot = inst.immForm.ra[4];
    end else if (isBcc) begin
      // condition code in low rd bits
      decoded.isBranch  = 1'b1;
      decoded.cond      = branchCond_e'(inst.regForm.rd[2:0]);
      // delay bit in rd[4] for conditionals
      decoded.delaySlot = inst.regForm.rd[4];
    end
  end

  // decode stage control register
  // flush wins so a resolved branch is dropped at once
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      ctrl <= nonBranch;
    end else if (flush) begin
      ctrl <= nonBranch;
    end else if (decEn) begin
      // squashed slot never branches
      if (squash) begin
        ctrl <= nonBranch;
      end else begin
        ctrl <= decoded;
      end
    end
  end

endmodule

// File: source/operandCapture.sv
`timescale 1ns/1ps

module operandCapture
  import branchPkg::*;
(
  input  logic        gclk,
  input  logic        arstN,
  input  logic        decEn,
  input  fwdSel_e     fwdSel,
  input  logic [31:0] regA,
  input  logic [31:0] aluResult,
  input  logic [31:0] ioReg,
  output opFlags_t    flags
);

  logic [31:0] operand;

  // forwarding mux as chosen by the hazard logic
  always_comb begin
    case (fwdSel)
      fwdAlu:  operand = aluResult;
      fwdIo:   operand = ioReg;
      // register file value otherwise
      default: operand = regA;
    endcase
  end

  // only zero and sign are kept
  // enough for every compare against zero
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      flags.isZero <= 1'b0;
      flags.isNeg  <= 1'b0;
    end else if (decEn) begin
      flags.isZero <= (operand == 32'd0);
      // signed view so msb is the sign
      flags.isNeg  <= operand[31];
    end
  end

endmodule

// File: source/branchResolve.sv
`timescale 1ns/1ps

module branchResolve
  import branchPkg::*;
(
  input  logic      gclk,
  input  logic      arstN,
  input  logic      decEn,
  input  logic      exeEn,
  input  condCtrl_t ctrl,
  input  opFlags_t  flags,
  output logic      taken,
  output logic      decSkip,
  output logic      flush,
  output logic      exeSkip,
  output logic      branchTaken
);

  logic condHolds;
  logic skipPend;

  // gt and ge built as inverted le and lt
  always_comb begin
    case (ctrl.cond)
      condEq:  condHolds = flags.isZero;
      condNe:  condHolds = !flags.isZero;
      condLt:  condHolds = flags.isNeg;
      condLe:  condHolds = flags.isNeg || flags.isZero;
      condGt:  condHolds = !(flags.isNeg || flags.isZero);
      condGe:  condHolds = !flags.isNeg;
      // reserved codes never branch
      default: condHolds = 1'b0;
    endcase
  end

  // unconditional ignores the flags
  assign taken = ctrl.isBranch && (ctrl.isUncond || condHolds);

  // squash next slot unless delay bit set
  // pending bit covers a flush that happened during a decode stall
  assign decSkip = (taken && !ctrl.delaySlot) || skipPend;

  // branch consumed once execute takes it
  assign flush = taken && exeEn;

  // squash still owed to the decode stage
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      skipPend <= 1'b0;
    end else if (decEn) begin
      skipPend <= 1'b0;
    end else if (decSkip) begin
      skipPend <= 1'b1;
    end
  end

  // execute stage copies
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      exeSkip     <= 1'b0;
      branchTaken <= 1'b0;
    end else if (exeEn) begin
      exeSkip     <= decSkip;
      branchTaken <= taken;
    end
  end

endmodule

// File: source/pcPipeline.sv
`timescale 1ns/1ps
`include "branchUnit_macros.svh"

module pcPipeline
  import branchPkg::*;
(
  input  logic                gclk,
  input  logic                arstN,
  input  logic                exeEn,
  input  logic                taken,
  input  logic [31:0]         aluResult,
  input  logic                fetchAdvance,
  output logic [31:0]         fetchAddr,
  output logic [`BU_PC_W-1:0] instPc,
  output logic [`BU_PC_W-1:0] curPc
);

  pcWord_t preIpc;
  pcWord_t nextWord;
  pcWord_t pcInc;

  // one word step when fetch moves on
  assign pcInc = {{(`BU_PC_W-1){1'b0}}, fetchAdvance};

  // target word from alu on a taken branch
  // otherwise sequential from last fetch
  assign nextWord = taken ? aluResult[31:32-`BU_PC_W] : (preIpc + pcInc);

  // byte address with low bits zero
  assign fetchAddr = {nextWord, {(32 - `BU_PC_W){1'b0}}};

  // three addresses in flight
  // fetch then decode then execute
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      preIpc <= '0;
      instPc <= '0;
      curPc  <= '0;
    end else if (exeEn) begin
      preIpc <= nextWord;
      instPc <= preIpc;
      curPc  <= instPc;
    end
  end

endmodule

// File: source/branchUnit.sv
`timescale 1ns/1ps
`include "branchUnit_macros.svh"

module branchUnit
  import branchPkg::*;
(
  input  logic                gclk,
  input  logic                arstN,
  input  logic                decEn,
  input  logic                exeEn,
  input  instWord_u           inst,
  input  fwdSel_e             fwdSel,
  input  logic [31:0]         regA,
  input  logic [31:0]         aluResult,
  input  logic [31:0]         ioReg,
  input  logic                fetchAdvance,
  output logic [31:0]         fetchAddr,
  output logic [`BU_PC_W-1:0] instPc,
  output logic [`BU_PC_W-1:0] curPc,
  output logic                decSkip,
  output logic                exeSkip,
  output logic                branchTaken
);

  condCtrl_t ctrl;
  opFlags_t  flags;
  logic      taken;
  logic      flush;

  // decode stage branch control
  branchDecode branchDecode_i (
    .gclk   (gclk),
    .arstN  (arstN),
    .decEn  (decEn),
    .inst   (inst),
    .squash (decSkip),
    .flush  (flush),
    .ctrl   (ctrl)
  );

  // compare operand flags
  operandCapture operandCapture_i (
    .gclk      (gclk),
    .arstN     (arstN),
    .decEn     (decEn),
    .fwdSel    (fwdSel),
    .regA      (regA),
    .aluResult (aluResult),
    .ioReg     (ioReg),
    .flags     (flags)
  );

  // taken and squash decision
  branchResolve branchResolve_i (
    .gclk        (gclk),
    .arstN       (arstN),
    .decEn       (decEn),
    .exeEn       (exeEn),
    .ctrl        (ctrl),
    .flags       (flags),
    .taken       (taken),
    .decSkip     (decSkip),
    .flush       (flush),
    .exeSkip     (exeSkip),
    .branchTaken (branchTaken)
  );

  // fetch address and pc stages
  pcPipeline pcPipeline_i (
    .gclk         (gclk),
    .arstN        (arstN),
    .exeEn        (exeEn),
    .taken        (taken),
    .aluResult    (aluResult),
    .fetchAdvance (fetchAdvance),
    .fetchAddr    (fetchAddr),
    .instPc       (instPc),
    .curPc        (curPc)
  );

endmodule

// File: bench/branchUnitTb.sv
`timescale 1ns/1ps
`include "branchUnit_macros.svh"

module branchUnitTb
  import branchPkg::*;
;

  // mirror of the unit state kept by the model
  typedef struct packed {
    logic                isBr;
    logic                isUnc;
    logic [2:0]          cond;
    logic                dly;
    logic [31:0]         opnd;
    logic                pend;
    logic                skipQ;
    logic                takenQ;
    logic [`BU_PC_W-1:0] pre;
    logic [`BU_PC_W-1:0] ipc;
    logic [`BU_PC_W-1:0] cpc;
  } refState_t;

  logic gclk, arstN, decEn, exeEn, fetchAdvance;
  instWord_u inst;
  fwdSel_e fwdSel;
  logic [31:0] regA, aluResult, ioReg, fetchAddr;
  logic [`BU_PC_W-1:0] instPc, curPc;
  logic decSkip, exeSkip, branchTaken;
  refState_t ms;
  integer seed = 32'hbf19;
  int checkCount = 0;
  int phaseLen [5] = '{20, 200, 300, 300, 300};

  branchUnit branchUnit_i (.*);

  initial begin
    gclk = 1'b0;
    forever #4 gclk = ~gclk;
  end

  task automatic stopOnFailure();
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
    stopOnFailure();
  endtask

  // signed compare of the operand against zero
  function automatic logic meetsCond(branchCond_e c, logic signed [31:0] v);
    case (c)
      condEq:  return v == 0;
      condNe:  return v != 0;
      condLt:  return v < 0;
      condLe:  return v <= 0;
      condGt:  return v > 0;
      condGe:  return v >= 0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic takesBranch(refState_t s);
    return s.isBr && (s.isUnc || meetsCond(branchCond_e'(s.cond), s.opnd));
  endfunction

  // squash the next slot unless the delay bit is set
  function automatic logic owesSquash(refState_t s);
    return (takesBranch(s) && !s.dly) || s.pend;
  endfunction

  // byte address of the next fetch
  // a taken branch jumps to the alu word
  // sequential fetch steps 4 bytes
  function automatic logic [31:0] nextFetch(refState_t s, logic [31:0] alu, logic adv);
    if (takesBranch(s))
      return {alu[31:2], 2'b00};
    return {s.pre, 2'b00} + (adv ? 32'd4 : 32'd0);
  endfunction

  function automatic logic [31:0] pickOperand(fwdSel_e f, logic [31:0] r, logic [31:0] a,
                                              logic [31:0] i);
    case (f)
      fwdAlu:  return a;
      fwdIo:   return i;
      default: return r;
    endcase
  endfunction

  // model state after one clock edge
  function automatic refState_t stepModel(refState_t s, instWord_u iw, logic [31:0] opnd,
                                          logic dEn, logic eEn, logic [31:0] alu, logic adv);
    refState_t n;
    logic tk, sk, isBru, isBcc;
    logic [31:0] nf;
    n = s;
    tk = takesBranch(s);
    sk = owesSquash(s);
    nf = nextFetch(s, alu, adv);
    isBru = (iw.regForm.opcode == `BU_OPC_BRU) || (iw.regForm.opcode == `BU_OPC_BRUI);
    isBcc = (iw.regForm.opcode == `BU_OPC_BCC) || (iw.regForm.opcode == `BU_OPC_BCCI);
    // a resolved taken branch is dropped
    if (tk && eEn) begin
      n.isBr = 1'b0;
    end else if (dEn) begin
      n.isBr  = (isBru || isBcc) && !sk;
      n.isUnc = isBru;
      n.cond  = iw.regForm.rd[2:0];
      n.dly   = isBru ? iw.immForm.ra[4] : iw.regForm.rd[4];
    end
    if (dEn)
      n.opnd = opnd;
    // squash owed while decode is stalled
    n.pend = !dEn && sk;
    if (eEn) begin
      n.skipQ  = sk;
      n.takenQ = tk;
      n.pre    = nf[31:2];
      n.ipc    = s.pre;
      n.cpc    = s.ipc;
    end
    return n;
  endfunction

  always @(posedge gclk or negedge arstN) begin
    if (!arstN)
      ms <= '0;
    else
      ms <= stepModel(ms, inst, pickOperand(fwdSel, regA, aluResult, ioReg),
                      decEn, exeEn, aluResult, fetchAdvance);
  end

  // outputs settled at the falling edge
  always @(negedge gclk) begin
    if (arstN) begin
      assert (branchTaken === ms.takenQ)
        else reportMismatch("branchTaken", 32'(branchTaken), 32'(ms.takenQ));
      assert (exeSkip === ms.skipQ)
        else reportMismatch("exeSkip", 32'(exeSkip), 32'(ms.skipQ));
      assert (decSkip === owesSquash(ms))
        else reportMismatch("decSkip", 32'(decSkip), 32'(owesSquash(ms)));
      assert (fetchAddr === nextFetch(ms, aluResult, fetchAdvance))
        else reportMismatch("fetchAddr", fetchAddr,
                            nextFetch(ms, aluResult, fetchAdvance));
      assert (instPc === ms.ipc)
        else reportMismatch("instPc", 32'(instPc), 32'(ms.ipc));
      assert (curPc === ms.cpc)
        else reportMismatch("curPc", 32'(curPc), 32'(ms.cpc));
      checkCount++;
    end
  end

  task automatic waitChecks(input int target, input string what);
    int waited;
    waited = 0;
    while (checkCount < target) begin
      @(posedge gclk);
      waited++;
      if (waited > 20) begin
        $display("timed out waiting for %s", what);
        stopOnFailure();
      end
    end
  endtask

  // phase 0 plain ops, 1 bru, 2 bcc, 3 mix, 4 mix with stalls
  task automatic driveCycle(input int phase);
    instWord_u w;
    logic [31:0] pick, opnd;
    logic [7:0] cnd;
    logic [1:0] fs;
    int kind;
    @(posedge gclk);
    w = $random(seed);
    pick = $random(seed);
    opnd = $random(seed);
    kind = phase;
    if (phase >= 3)
      kind = (pick[2:1] == 2'd3) ? 2 : int'(pick[2:1]);
    case (kind)
      1: w.regForm.opcode = pick[0] ? `BU_OPC_BRU : `BU_OPC_BRUI;
      2: w.regForm.opcode = pick[0] ? `BU_OPC_BCC : `BU_OPC_BCCI;
      // msb clear keeps it off every branch opcode
      default: w.regForm.opcode = {1'b0, w.regForm.opcode[4:0]};
    endcase
    cnd = pick[15:8] % 8'd6;
    if (kind == 2)
      w.regForm.rd[2:0] = cnd[2:0];
    // bias operand toward zero and negative values
    case (pick[5:4])
      2'd0: opnd = 32'd0;
      2'd1: opnd = opnd | 32'h8000_0000;
      2'd3: opnd = 32'd1;
      default: ;
    endcase
    fs = (pick[7:6] == 2'd3) ? 2'd0 : pick[7:6];
    inst         <= w;
    fwdSel       <= fwdSel_e'(fs);
    regA         <= (fs == 2'd0) ? opnd : $random(seed);
    aluResult    <= (fs == 2'd1) ? opnd : $random(seed);
    ioReg        <= (fs == 2'd2) ? opnd : $random(seed);
    fetchAdvance <= pick[16];
    decEn        <= (phase == 4) ? pick[17] : 1'b1;
    exeEn        <= (phase == 4) ? pick[18] : 1'b1;
  endtask

  initial begin
    int target;
    arstN = 1'b0;
    decEn = 1'b0;
    exeEn = 1'b0;
    inst = '0;
    fwdSel = fwdReg;
    regA = '0;
    aluResult = '0;
    ioReg = '0;
    fetchAdvance = 1'b0;
    repeat (8) @(posedge gclk);
    arstN <= 1'b1;
    waitChecks(1, "reset release");
    for (int p = 0; p < 5; p++) begin
      target = checkCount + phaseLen[p];
      for (int i = 0; i < phaseLen[p]; i++)
        driveCycle(p);
      waitChecks(target, "end of stimulus phase");
    end
    $display("sim passed");
    $finish;
  end

endmodule

// File: src.f
+incdir+source
source/branchPkg.sv
source/branchDecode.sv
source/operandCapture.sv
source/branchResolve.sv
source/pcPipeline.sv
source/branchUnit.sv
bench/branchUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the branch unit testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project root"
  exit 1
fi

verilator --binary --timing --assert -f src.f --top-module branchUnitTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "verilator build returned an error"
  exit 1
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi
exit 0
